//--- Bender.yml
package:
  name: icache

sources:
  - source/icache_pkg.sv
  - source/icache_array.sv
  - source/fetch_read_stage.sv
  - source/fill_ctrl.sv
  - source/inval_sweep.sv
  - source/icache_top.sv
  - target: test
    files:
      - verification/icache_tb.sv

//--- source/fetch_read_stage.sv
`timescale 1ns/100ps

module fetch_read_stage (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            req_valid,
  input  logic [icache_pkg::OFFSET_W-1:0] offset,
  input  logic [icache_pkg::LINE_W-1:0]   line,
  input  logic                            tag_ok,
  input  logic                            stall,
  input  logic                            except,
  output icache_pkg::fetch_rsp_t          rsp
);
  import icache_pkg::*;

  logic                req_q;
  logic [OFFSET_W-1:0] off_q;
  logic                hit;
  logic [WORD_W-1:0]   word;
  fetch_rsp_t          hold_q;

  // line up request with the array output
  always_ff @(posedge clk) begin
    if (rst) begin
      req_q <= 1'b0;
    end else begin
      req_q <= req_valid;
    end
  end

  always_ff @(posedge clk) begin
    off_q <= offset;
  end

  assign hit  = req_q && tag_ok;
  // word is zero on a miss
  assign word = hit ? line[off_q*WORD_W +: WORD_W] : '0;

  // exception wins over stall
  always_ff @(posedge clk) begin
    if (rst) begin
      hold_q <= '0;
    end else if (except) begin
      hold_q.valid <= 1'b0;
      hold_q.hit   <= 1'b0;
    end else if (!stall) begin
      hold_q <= '{valid: req_q, hit: hit, word: word};
    end
  end

  assign rsp = hold_q;

endmodule

//--- source/fill_ctrl.sv
`timescale 1ns/100ps

module fill_ctrl (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   fill_req,
  input  icache_pkg::fill_beat_t fill_beat,
  output logic                   fill_ack,
  input  logic                   inval,
  input  logic                   sweep_done,
  output logic                   sweep_run,
  output icache_pkg::line_wr_t   wr,
  output logic                   busy
);
  import icache_pkg::*;

  fill_state_e            state_q;
  fill_state_e            state_d;
  logic                   cap_lo;
  logic                   cap_hi;
  logic [LINE_ADDR_W-1:0] addr_q;
  logic [HALF_W-1:0]      lo_q;
  logic [HALF_W-1:0]      hi_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        // invalidate takes the slot, a pending fill waits
        if (inval) begin
          state_d = SWEEP;
        end else if (fill_req) begin
          state_d = LO_ACK;
        end
      end
      LO_ACK:  if (!fill_req) state_d = LO_REL;
      LO_REL:  if (fill_req) state_d = HI_ACK;
      HI_ACK:  if (!fill_req) state_d = HI_REL;
      HI_REL:  state_d = WRITE;
      WRITE:   state_d = IDLE;
      SWEEP:   if (sweep_done) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // beats are taken on the req edge, ack follows a cycle later
  assign cap_lo = (state_q == IDLE) && (state_d == LO_ACK);
  assign cap_hi = (state_q == LO_REL) && (state_d == HI_ACK);

  always_ff @(posedge clk) begin
    if (cap_lo) begin
      addr_q <= fill_beat.line_addr;
      lo_q   <= fill_beat.data;
    end
    if (cap_hi) begin
      hi_q <= fill_beat.data;
    end
  end

  assign fill_ack  = (state_q == LO_ACK) || (state_q == HI_ACK);
  assign sweep_run = (state_q == SWEEP);
  assign busy      = (state_q != IDLE);
  assign wr        = '{en: state_q == WRITE, line_addr: addr_q, data: {hi_q, lo_q}};

  // handshake order seen from the source side
  assert property (@(posedge clk) disable iff (rst) $rose(fill_ack) |-> $past(fill_req));

endmodule

//--- source/icache_array.sv
`timescale 1ns/100ps

module icache_array (
  input  logic                          clk,
  input  logic                          rst,
  input  icache_pkg::fetch_req_t        rd_a,
  input  icache_pkg::fetch_req_t        rd_b,
  output logic [icache_pkg::LINE_W-1:0] line_a,
  output logic [icache_pkg::LINE_W-1:0] line_b,
  output logic                          tag_ok_a,
  output logic                          tag_ok_b,
  input  icache_pkg::line_wr_t          wr,
  input  logic                          clr_en,
  input  logic [icache_pkg::INDEX_W-1:0] clr_set,
  output icache_pkg::evict_t            evict
);
  import icache_pkg::*;

  logic [TAG_W-1:0]       tag_mem  [SETS];
  logic [LINE_W-1:0]      data_mem [SETS];
  logic [SETS-1:0]        valid_q;

  logic [INDEX_W-1:0]     idx_a;
  logic [INDEX_W-1:0]     idx_b;
  logic [INDEX_W-1:0]     wr_idx;
  logic [TAG_W-1:0]       wr_tag;
  logic                   evict_valid_q;
  logic [LINE_ADDR_W-1:0] evict_addr_q;

  // valid set whose stored tag matches the address tag
  function automatic logic tag_match(input logic [ADDR_W-1:0] addr);
    logic [INDEX_W-1:0] idx;
    idx = addr[OFFSET_W +: INDEX_W];
    return valid_q[idx] && (tag_mem[idx] == addr[ADDR_W-1 -: TAG_W]);
  endfunction

  assign idx_a  = rd_a.addr[OFFSET_W +: INDEX_W];
  assign idx_b  = rd_b.addr[OFFSET_W +: INDEX_W];
  assign wr_idx = wr.line_addr[INDEX_W-1:0];
  assign wr_tag = wr.line_addr[LINE_ADDR_W-1 -: TAG_W];

  // read port a
  always_ff @(posedge clk) begin
    if (rd_a.valid) begin
      line_a   <= data_mem[idx_a];
      tag_ok_a <= tag_match(rd_a.addr);
    end
  end

  // read port b
  always_ff @(posedge clk) begin
    if (rd_b.valid) begin
      line_b   <= data_mem[idx_b];
      tag_ok_b <= tag_match(rd_b.addr);
    end
  end

  always_ff @(posedge clk) begin
    if (wr.en) begin
      tag_mem[wr_idx]  <= wr_tag;
      data_mem[wr_idx] <= wr.data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (wr.en) begin
      valid_q[wr_idx] <= 1'b1;
    end else if (clr_en) begin
      valid_q[clr_set] <= 1'b0;
    end
  end

  // old line address leaves as the new line lands
  always_ff @(posedge clk) begin
    if (rst) begin
      evict_valid_q <= 1'b0;
    end else begin
      evict_valid_q <= wr.en && valid_q[wr_idx] && (tag_mem[wr_idx] != wr_tag);
    end
  end

  always_ff @(posedge clk) begin
    if (wr.en) begin
      evict_addr_q <= {tag_mem[wr_idx], wr_idx};
    end
  end

  assign evict = '{valid: evict_valid_q, line_addr: evict_addr_q};

  // fill writes and the invalidate sweep never overlap
  assert property (@(posedge clk) disable iff (rst) !(wr.en && clr_en));

endmodule

//--- source/icache_pkg.sv
package icache_pkg;

  // fetch word and line geometry
  localparam int WORD_W      = 32;
  localparam int LINE_WORDS  = 4;
  localparam int LINE_W      = WORD_W * LINE_WORDS;
  localparam int HALF_W      = LINE_W / 2;

  // word address split as tag | index | offset
  localparam int ADDR_W      = 16;
  localparam int OFFSET_W    = 2;
  localparam int INDEX_W     = 4;
  localparam int SETS        = 1 << INDEX_W;
  localparam int TAG_W       = ADDR_W - INDEX_W - OFFSET_W;
  localparam int LINE_ADDR_W = ADDR_W - OFFSET_W;

  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] addr;
  } fetch_req_t;

  typedef struct packed {
    logic              valid;
    logic              hit;
    logic [WORD_W-1:0] word;
  } fetch_rsp_t;

  // one half-line beat of a fill
  typedef struct packed {
    logic [LINE_ADDR_W-1:0] line_addr;
    logic [HALF_W-1:0]      data;
  } fill_beat_t;

  typedef struct packed {
    logic                   valid;
    logic [LINE_ADDR_W-1:0] line_addr;
  } evict_t;

  // full line write from the fill controller
  typedef struct packed {
    logic                   en;
    logic [LINE_ADDR_W-1:0] line_addr;
    logic [LINE_W-1:0]      data;
  } line_wr_t;

  typedef enum logic [2:0] {
    IDLE, LO_ACK, LO_REL, HI_ACK, HI_REL, WRITE, SWEEP
  } fill_state_e;

endpackage

//--- source/icache_top.sv
`timescale 1ns/100ps

module icache_top (
  input  logic                   clk,
  input  logic                   rst,
  input  icache_pkg::fetch_req_t fetch_a,
  input  icache_pkg::fetch_req_t fetch_b,
  input  logic                   stall_a,
  input  logic                   stall_b,
  input  logic                   except_a,
  input  logic                   except_b,
  output icache_pkg::fetch_rsp_t rsp_a,
  output icache_pkg::fetch_rsp_t rsp_b,
  input  logic                   fill_req,
  input  icache_pkg::fill_beat_t fill_beat,
  output logic                   fill_ack,
  input  logic                   inval,
  output logic                   busy,
  output icache_pkg::evict_t     evict
);
  import icache_pkg::*;

  logic [LINE_W-1:0]  line_a;
  logic [LINE_W-1:0]  line_b;
  logic               tag_ok_a;
  logic               tag_ok_b;
  line_wr_t           wr;
  logic               sweep_run;
  logic               sweep_done;
  logic [INDEX_W-1:0] clr_set;

  icache_array array_i (
    .clk(clk), .rst(rst), .rd_a(fetch_a), .rd_b(fetch_b),
    .line_a(line_a), .line_b(line_b), .tag_ok_a(tag_ok_a), .tag_ok_b(tag_ok_b),
    .wr(wr), .clr_en(sweep_run), .clr_set(clr_set), .evict(evict)
  );

  fetch_read_stage read_a_i (
    .clk(clk), .rst(rst), .req_valid(fetch_a.valid), .offset(fetch_a.addr[OFFSET_W-1:0]),
    .line(line_a), .tag_ok(tag_ok_a), .stall(stall_a), .except(except_a), .rsp(rsp_a)
  );

  fetch_read_stage read_b_i (
    .clk(clk), .rst(rst), .req_valid(fetch_b.valid), .offset(fetch_b.addr[OFFSET_W-1:0]),
    .line(line_b), .tag_ok(tag_ok_b), .stall(stall_b), .except(except_b), .rsp(rsp_b)
  );

  fill_ctrl fill_ctrl_i (
    .clk(clk), .rst(rst), .fill_req(fill_req), .fill_beat(fill_beat), .fill_ack(fill_ack),
    .inval(inval), .sweep_done(sweep_done), .sweep_run(sweep_run), .wr(wr), .busy(busy)
  );

  inval_sweep sweep_i (
    .clk(clk), .rst(rst), .run(sweep_run), .clr_set(clr_set), .sweep_done(sweep_done)
  );

endmodule

//--- source/inval_sweep.sv
`timescale 1ns/100ps

module inval_sweep (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           run,
  output logic [icache_pkg::INDEX_W-1:0] clr_set,
  output logic                           sweep_done
);
  import icache_pkg::*;

  logic [INDEX_W-1:0] cnt_q;

  // restarts from set 0 whenever run is low
  always_ff @(posedge clk) begin
    if (rst || !run) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign clr_set    = cnt_q;
  assign sweep_done = run && (cnt_q == INDEX_W'(SETS - 1));

  // controller leaves the sweep right after the last set
  assert property (@(posedge clk) disable iff (rst) sweep_done |-> run ##1 !run);

endmodule

//--- verification/icache_tb.sv
`timescale 1ns/100ps

module icache_tb;
  import icache_pkg::*;

  localparam int MAX_WAIT = 64;

  typedef enum logic [2:0] {OP_FILL, OP_READ, OP_STALL, OP_EXCEPT, OP_INVAL} op_e;

  typedef struct packed {
    op_e                    op;
    logic                   port;
    logic [ADDR_W-1:0]      addr;
    logic                   hit;
    logic                   ev_valid;
    logic [LINE_ADDR_W-1:0] ev_addr;
  } row_t;

  logic       clk = 1'b0;
  logic       rst;
  fetch_req_t fetch_a;
  fetch_req_t fetch_b;
  logic       stall_a;
  logic       stall_b;
  logic       except_a;
  logic       except_b;
  fetch_rsp_t rsp_a;
  fetch_rsp_t rsp_b;
  logic       fill_req;
  fill_beat_t fill_beat;
  logic       fill_ack;
  logic       inval;
  logic       busy;
  evict_t     evict;
  row_t       rows[$];

  icache_top icache_top_i (
    .clk(clk), .rst(rst), .fetch_a(fetch_a), .fetch_b(fetch_b),
    .stall_a(stall_a), .stall_b(stall_b), .except_a(except_a), .except_b(except_b),
    .rsp_a(rsp_a), .rsp_b(rsp_b), .fill_req(fill_req), .fill_beat(fill_beat),
    .fill_ack(fill_ack), .inval(inval), .busy(busy), .evict(evict)
  );

  always #20 clk = ~clk;

  // word w of a line holds the line address up top and w below
  function automatic logic [WORD_W-1:0] rule_word(input logic [ADDR_W-1:0] addr);
    return {2'b00, addr[ADDR_W-1:OFFSET_W], 14'h0, addr[OFFSET_W-1:0]};
  endfunction

  function automatic logic [HALF_W-1:0] rule_half(input logic [LINE_ADDR_W-1:0] line,
                                                  input logic hi);
    logic [ADDR_W-1:0] base;
    base = {line, hi, 1'b0};
    return {rule_word(base + 16'd1), rule_word(base)};
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp) else begin
      $display("Fail %s: got %h, expected %h", name, got, exp);
      $display(">>> FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("Timed out waiting for %s", what);
    $display(">>> FAIL");
    $fatal(1, "timeout");
  endtask

  task automatic wait_ack(input logic level);
    int n;
    n = 0;
    while (fill_ack !== level) begin
      @(negedge clk);
      n++;
      if (n > MAX_WAIT) stop_on_timeout("fill_ack");
    end
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (busy !== 1'b0) begin
      @(negedge clk);
      n++;
      if (n > MAX_WAIT) stop_on_timeout("busy to fall");
    end
  endtask

  task automatic fill_line(input logic [LINE_ADDR_W-1:0] line, output evict_t ev);
    // no ack before the request
    check_value("fill_ack", fill_ack, 0);
    fill_req  = 1'b1;
    fill_beat = '{line_addr: line, data: rule_half(line, 1'b0)};
    wait_ack(1'b1);
    check_value("busy", busy, 1);
    // ack holds while req is still up
    @(negedge clk);
    check_value("fill_ack", fill_ack, 1);
    fill_req = 1'b0;
    wait_ack(1'b0);
    // second beat line address is ignored by the cache
    fill_req  = 1'b1;
    fill_beat = '{line_addr: ~line, data: rule_half(line, 1'b1)};
    wait_ack(1'b1);
    fill_req = 1'b0;
    wait_ack(1'b0);
    check_value("busy", busy, 1);
    wait_idle();
    ev = evict;
    @(negedge clk);
    check_value("evict.valid", evict.valid, 0);
  endtask

  task automatic issue_read(input logic [1:0] ports, input logic [ADDR_W-1:0] addr);
    fetch_a = '{valid: ports[0], addr: addr};
    fetch_b = '{valid: ports[1], addr: addr};
    @(negedge clk);
    fetch_a.valid = 1'b0;
    fetch_b.valid = 1'b0;
    @(negedge clk);
  endtask

  task automatic check_rsp(input logic port, input logic [ADDR_W-1:0] addr, input logic hit);
    fetch_rsp_t rsp;
    string      nm;
    rsp = port ? rsp_b : rsp_a;
    nm  = port ? "rsp_b" : "rsp_a";
    check_value({nm, ".valid"}, rsp.valid, 1);
    check_value({nm, ".hit"}, rsp.hit, hit);
    check_value({nm, ".word"}, rsp.word, hit ? rule_word(addr) : 32'h0);
  endtask

  task automatic apply_row(input row_t row);
    evict_t     ev;
    fetch_rsp_t held;
    string      nm;
    nm = row.port ? "rsp_b" : "rsp_a";
    case (row.op)
      OP_FILL: begin
        fill_line(row.addr[ADDR_W-1:OFFSET_W], ev);
        check_value("evict.valid", ev.valid, row.ev_valid);
        if (row.ev_valid) check_value("evict.line_addr", ev.line_addr, row.ev_addr);
      end
      OP_READ: begin
        issue_read(row.port ? 2'b10 : 2'b01, row.addr);
        check_rsp(row.port, row.addr, row.hit);
      end
      OP_STALL: begin
        issue_read(row.port ? 2'b10 : 2'b01, row.addr);
        check_rsp(row.port, row.addr, row.hit);
        held    = row.port ? rsp_b : rsp_a;
        stall_a = !row.port;
        stall_b = row.port;
        repeat (3) begin
          @(negedge clk);
          check_value({nm, " under stall"}, row.port ? rsp_b : rsp_a, held);
        end
        stall_a = 1'b0;
        stall_b = 1'b0;
      end
      OP_EXCEPT: begin
        issue_read(2'b11, row.addr);
        check_rsp(1'b0, row.addr, row.hit);
        check_rsp(1'b1, row.addr, row.hit);
        // both held, exception on one side only
        stall_a  = 1'b1;
        stall_b  = 1'b1;
        except_a = !row.port;
        except_b = row.port;
        @(negedge clk);
        held = row.port ? rsp_b : rsp_a;
        check_value({nm, ".valid"}, held.valid, 0);
        check_value({nm, ".hit"}, held.hit, 0);
        check_rsp(!row.port, row.addr, row.hit);
        stall_a  = 1'b0;
        stall_b  = 1'b0;
        except_a = 1'b0;
        except_b = 1'b0;
      end
      default: begin
        inval = 1'b1;
        @(negedge clk);
        inval = 1'b0;
        check_value("busy", busy, 1);
        wait_idle();
      end
    endcase
  endtask

  initial begin
    rst       = 1'b1;
    fetch_a   = '0;
    fetch_b   = '0;
    stall_a   = 1'b0;
    stall_b   = 1'b0;
    except_a  = 1'b0;
    except_b  = 1'b0;
    fill_req  = 1'b0;
    fill_beat = '0;
    inval     = 1'b0;
    // op, port, addr, hit, evict valid, evict line
    rows = '{
      '{OP_READ,   1'b0, 16'h048c, 1'b0, 1'b0, 14'h0000},
      '{OP_READ,   1'b1, 16'h048d, 1'b0, 1'b0, 14'h0000},
      '{OP_FILL,   1'b0, 16'h048c, 1'b0, 1'b0, 14'h0000},
      '{OP_READ,   1'b0, 16'h048c, 1'b1, 1'b0, 14'h0000},
      '{OP_READ,   1'b0, 16'h048d, 1'b1, 1'b0, 14'h0000},
      '{OP_READ,   1'b0, 16'h048e, 1'b1, 1'b0, 14'h0000},
      '{OP_READ,   1'b0, 16'h048f, 1'b1, 1'b0, 14'h0000},
      '{OP_READ,   1'b1, 16'h048c, 1'b1, 1'b0, 14'h0000},
      '{OP_READ,   1'b1, 16'h048d, 1'b1, 1'b0, 14'h0000},
      '{OP_READ,   1'b1, 16'h048e, 1'b1, 1'b0, 14'h0000},
      '{OP_READ,   1'b1, 16'h048f, 1'b1, 1'b0, 14'h0000},
      '{OP_READ,   1'b0, 16'h0490, 1'b0, 1'b0, 14'h0000},
      '{OP_FILL,   1'b0, 16'h048c, 1'b0, 1'b0, 14'h0000},
      '{OP_FILL,   1'b0, 16'h08cc, 1'b0, 1'b1, 14'h0123},
      '{OP_READ,   1'b0, 16'h048c, 1'b0, 1'b0, 14'h0000},
      '{OP_READ,   1'b1, 16'h08ce, 1'b1, 1'b0, 14'h0000},
      '{OP_FILL,   1'b0, 16'h0114, 1'b0, 1'b0, 14'h0000},
      '{OP_STALL,  1'b0, 16'h08cd, 1'b1, 1'b0, 14'h0000},
      '{OP_EXCEPT, 1'b1, 16'h0115, 1'b1, 1'b0, 14'h0000},
      '{OP_EXCEPT, 1'b0, 16'h0116, 1'b1, 1'b0, 14'h0000},
      '{OP_FILL,   1'b0, 16'h003c, 1'b0, 1'b0, 14'h0000},
      '{OP_READ,   1'b1, 16'h003d, 1'b1, 1'b0, 14'h0000},
      '{OP_INVAL,  1'b0, 16'h0000, 1'b0, 1'b0, 14'h0000},
      '{OP_READ,   1'b0, 16'h08cc, 1'b0, 1'b0, 14'h0000},
      '{OP_READ,   1'b1, 16'h08cf, 1'b0, 1'b0, 14'h0000},
      '{OP_READ,   1'b0, 16'h0114, 1'b0, 1'b0, 14'h0000},
      '{OP_READ,   1'b1, 16'h0117, 1'b0, 1'b0, 14'h0000},
      '{OP_READ,   1'b0, 16'h003f, 1'b0, 1'b0, 14'h0000}
    };
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    // idle outputs straight out of reset
    check_value("busy", busy, 0);
    check_value("fill_ack", fill_ack, 0);
    check_value("evict.valid", evict.valid, 0);
    check_value("rsp_a.valid", rsp_a.valid, 0);
    check_value("rsp_a.hit", rsp_a.hit, 0);
    check_value("rsp_b.valid", rsp_b.valid, 0);
    check_value("rsp_b.hit", rsp_b.hit, 0);
    foreach (rows[i]) begin
      apply_row(rows[i]);
    end
    $display(">>> PASS");
    $finish;
  end

endmodule

//--- vlog.f
source/icache_pkg.sv
source/icache_array.sv
source/fetch_read_stage.sv
source/fill_ctrl.sv
source/inval_sweep.sv
source/icache_top.sv
verification/icache_tb.sv
